// ==== list.f ====
logic/cpuPkg.sv
logic/aluStage.sv
logic/decimalAdjust.sv
logic/busRouting.sv
logic/userRegs.sv
logic/statusFlags.sv
logic/programCounter.sv
logic/execDatapath.sv
verification/tbExecDatapath.sv

// ==== logic/aluStage.sv ====
/* byte-wide ALU with the adder hold register and the flags
   captured alongside the result */
`timescale 1ns/1ps

module aluStage import cpuPkg::*; (
    input  logic  phi2,
    input  logic  rstAll,
    input  byteT  aluA,
    input  byteT  aluB,
    input  aluOpT aluOp,
    input  logic  carryIn,
    output byteT  holdVal,
    output logic  heldV,
    output logic  heldC,
    output logic  heldH,
    output logic  aluC,
    output logic  aluH
);

    logic [8:0] sumFull;
    logic [4:0] sumLow;
    byteT       resultVal;
    logic       resultC;
    logic       resultV;

    assign sumFull = {1'b0, aluA} + {1'b0, aluB} + {8'h00, carryIn};
    // low nibble carry, needed by the decimal adjuster
    assign sumLow = {1'b0, aluA[3:0]} + {1'b0, aluB[3:0]} + {4'h0, carryIn};

    always_comb begin
        resultVal = sumFull[7:0];
        resultC   = 1'b0;
        resultV   = 1'b0;
        case (aluOp)
            aluSum: begin
                resultVal = sumFull[7:0];
                resultC   = sumFull[8];
                // same operand signs, different result sign
                resultV   = (aluA[7] == aluB[7]) && (aluA[7] != sumFull[7]);
            end
            aluAnd:        resultVal = aluA & aluB;
            aluEor:        resultVal = aluA ^ aluB;
            aluOr:         resultVal = aluA | aluB;
            aluShiftRight: begin
                resultVal = {carryIn, aluB[7:1]};
                resultC   = aluB[0];
            end
            default:       resultVal = 8'h00;
        endcase
    end

    assign aluC = resultC;
    assign aluH = (aluOp == aluSum) && sumLow[4];

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            holdVal <= 8'h00;
            heldV   <= 1'b0;
            heldC   <= 1'b0;
            heldH   <= 1'b0;
        end else begin
            holdVal <= resultVal;
            heldV   <= resultV;
            heldC   <= resultC;
            heldH   <= aluH;
        end
    end

endmodule

// ==== logic/busRouting.sv ====
/* input data latch and the SB, DB and ALU operand selects that
   stand in for the internal tri-state buses */
`timescale 1ns/1ps

module busRouting import cpuPkg::*; (
    input  logic  phi2,
    input  logic  rstAll,
    input  byteT  dataIn,
    input  sbSrcT sbSrc,
    input  dbSrcT dbSrc,
    input  aSelT  aSel,
    input  bSelT  bSel,
    input  byteT  accVal,
    input  byteT  xVal,
    input  byteT  yVal,
    input  byteT  holdVal,
    output byteT  sbBus,
    output byteT  dbBus,
    output byteT  aluA,
    output byteT  aluB,
    output byteT  dataLatch,
    output byteT  prevData
);

    // prevData keeps the byte latched one edge before
    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            dataLatch <= 8'h00;
            prevData  <= 8'h00;
        end else begin
            dataLatch <= dataIn;
            prevData  <= dataLatch;
        end
    end

    always_comb begin
        case (sbSrc)
            sbAcc:   sbBus = accVal;
            sbX:     sbBus = xVal;
            sbY:     sbBus = yVal;
            sbHold:  sbBus = holdVal;
            sbData:  sbBus = dataLatch;
            default: sbBus = 8'h00;
        endcase
    end

    assign dbBus = (dbSrc == dbAcc) ? accVal : dataLatch;

    assign aluA = (aSel == aSb) ? sbBus : 8'h00;

    always_comb begin
        case (bSel)
            bDb:     aluB = dbBus;
            // inverted operand for subtract and compare
            bDbInv:  aluB = ~dbBus;
            default: aluB = 8'h00;
        endcase
    end

endmodule

// ==== logic/cpuPkg.sv ====
/* shared types for the execution datapath of the 6502-style core:
   data widths, status bit positions and the control selects */
package cpuPkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;
    typedef logic [7:0]  statusT;

    // NV-BDIZC bit positions
    localparam int statusC = 0;
    localparam int statusZ = 1;
    localparam int statusI = 2;
    localparam int statusD = 3;
    localparam int statusV = 6;
    localparam int statusN = 7;

    // only the unused bit 5 reads as one after reset
    localparam statusT statusReset = 8'h20;

    typedef enum logic [2:0] {
        aluSum,
        aluAnd,
        aluEor,
        aluOr,
        aluShiftRight
    } aluOpT;

    // special bus source
    typedef enum logic [2:0] {
        sbAcc,
        sbX,
        sbY,
        sbHold,
        sbData
    } sbSrcT;

    // data bus source
    typedef enum logic {
        dbData,
        dbAcc
    } dbSrcT;

    typedef enum logic {
        aZero,
        aSb
    } aSelT;

    typedef enum logic [1:0] {
        bZero,
        bDb,
        bDbInv
    } bSelT;

    // which flags the status register takes at the edge
    typedef enum logic [2:0] {
        flagsNone,
        flagsNzcv,
        flagsNz,
        flagsNzc,
        flagsBit
    } flagModeT;

endpackage

// ==== logic/decimalAdjust.sv ====
/* BCD correction of the special bus after a decimal add or subtract */
`timescale 1ns/1ps

module decimalAdjust import cpuPkg::*; (
    input  logic phi2,
    input  logic rstAll,
    input  logic decimalAdd,
    input  logic decimalSub,
    input  logic aluC,
    input  logic aluH,
    input  byteT sbBus,
    output byteT adjVal,
    output logic bcdCarry
);

    logic addQ;
    logic subQ;
    logic carryQ;
    logic halfQ;
    logic upperFix;

    // strobes and carries travel with the sum into the hold register cycle
    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            addQ   <= 1'b0;
            subQ   <= 1'b0;
            carryQ <= 1'b0;
            halfQ  <= 1'b0;
        end else begin
            addQ   <= decimalAdd;
            subQ   <= decimalSub;
            carryQ <= aluC;
            halfQ  <= aluH;
        end
    end

    assign upperFix = carryQ || (sbBus > 8'h99);

    always_comb begin
        adjVal = sbBus;
        if (addQ) begin
            if ((sbBus[3:0] > 4'd9) || halfQ) begin
                adjVal = adjVal + 8'h06;
            end
            if (upperFix) begin
                adjVal = adjVal + 8'h60;
            end
        end else if (subQ) begin
            // a borrow out of a digit leaves it six too high
            if (!halfQ) begin
                adjVal = adjVal - 8'h06;
            end
            if (!carryQ) begin
                adjVal = adjVal - 8'h60;
            end
        end
    end

    assign bcdCarry = addQ && upperFix;

    // add and subtract adjust are exclusive per micro-step
    assert property (@(posedge phi2) disable iff (rstAll)
        !(decimalAdd && decimalSub));

endmodule

// ==== logic/execDatapath.sv ====
/* execution datapath top: bus routing, ALU, decimal adjust,
   user registers, status and program counter */
`timescale 1ns/1ps

module execDatapath import cpuPkg::*; (
    input  logic     phi2,
    input  logic     rstAll,
    input  byteT     dataIn,
    input  sbSrcT    sbSrc,
    input  dbSrcT    dbSrc,
    input  aSelT     aSel,
    input  bSelT     bSel,
    input  aluOpT    aluOp,
    input  logic     carryIn,
    input  logic     decimalAdd,
    input  logic     decimalSub,
    input  logic     loadAc,
    input  logic     loadX,
    input  logic     loadY,
    input  flagModeT flagMode,
    input  logic     setC,
    input  logic     clrC,
    input  logic     setI,
    input  logic     clrI,
    input  logic     clrV,
    input  logic     setD,
    input  logic     clrD,
    input  logic     pcLoad,
    input  logic     pcInc,
    output byteT     accVal,
    output byteT     xVal,
    output byteT     yVal,
    output statusT   status,
    output addrT     pcVal
);

    byteT sbBus;
    byteT dbBus;
    byteT aluA;
    byteT aluB;
    byteT dataLatch;
    byteT prevData;
    byteT holdVal;
    byteT adjVal;
    logic heldV;
    logic heldC;
    logic aluC;
    logic aluH;
    logic bcdCarry;

    busRouting i_busRouting (
        .phi2(phi2), .rstAll(rstAll), .dataIn(dataIn),
        .sbSrc(sbSrc), .dbSrc(dbSrc), .aSel(aSel), .bSel(bSel),
        .accVal(accVal), .xVal(xVal), .yVal(yVal), .holdVal(holdVal),
        .sbBus(sbBus), .dbBus(dbBus), .aluA(aluA), .aluB(aluB),
        .dataLatch(dataLatch), .prevData(prevData)
    );

    // half carry reaches the adjuster directly, the held copy stays local
    aluStage i_aluStage (
        .phi2(phi2), .rstAll(rstAll), .aluA(aluA), .aluB(aluB),
        .aluOp(aluOp), .carryIn(carryIn), .holdVal(holdVal),
        .heldV(heldV), .heldC(heldC), .heldH(), .aluC(aluC), .aluH(aluH)
    );

    decimalAdjust i_decimalAdjust (
        .phi2(phi2), .rstAll(rstAll), .decimalAdd(decimalAdd),
        .decimalSub(decimalSub), .aluC(aluC), .aluH(aluH), .sbBus(sbBus),
        .adjVal(adjVal), .bcdCarry(bcdCarry)
    );

    userRegs i_userRegs (
        .phi2(phi2), .rstAll(rstAll), .sbBus(sbBus), .adjVal(adjVal),
        .loadAc(loadAc), .loadX(loadX), .loadY(loadY),
        .accVal(accVal), .xVal(xVal), .yVal(yVal)
    );

    statusFlags i_statusFlags (
        .phi2(phi2), .rstAll(rstAll), .flagMode(flagMode), .adjVal(adjVal),
        .dbBus(dbBus), .heldV(heldV), .heldC(heldC), .bcdCarry(bcdCarry),
        .setC(setC), .clrC(clrC), .setI(setI), .clrI(clrI), .clrV(clrV),
        .setD(setD), .clrD(clrD), .status(status)
    );

    programCounter i_programCounter (
        .phi2(phi2), .rstAll(rstAll), .pcLoad(pcLoad), .pcInc(pcInc),
        .dataLatch(dataLatch), .prevData(prevData), .pcVal(pcVal)
    );

endmodule

// ==== logic/programCounter.sv ====
/* 16-bit program counter, loaded from two latched bytes or
   advanced by a byte-wise carry-chained incrementer */
`timescale 1ns/1ps

module programCounter import cpuPkg::*; (
    input  logic phi2,
    input  logic rstAll,
    input  logic pcLoad,
    input  logic pcInc,
    input  byteT dataLatch,
    input  byteT prevData,
    output addrT pcVal
);

    byteT       pcLow;
    byteT       pcHigh;
    logic [8:0] lowNext;
    byteT       highNext;

    // carry out of the low incrementer advances the high byte
    assign lowNext  = {1'b0, pcLow} + 9'd1;
    assign highNext = pcHigh + {7'h00, lowNext[8]};

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            pcLow  <= 8'h00;
            pcHigh <= 8'h00;
        end else if (pcLoad) begin
            pcLow  <= dataLatch;
            pcHigh <= prevData;
        end else if (pcInc) begin
            pcLow  <= lowNext[7:0];
            pcHigh <= highNext;
        end
    end

    assign pcVal = {pcHigh, pcLow};

    // a jump never coincides with a fetch advance
    assert property (@(posedge phi2) disable iff (rstAll) !(pcLoad && pcInc));

endmodule

// ==== logic/statusFlags.sv ====
/* NV-DIZC status register, updated by flag mode or by the
   set and clear strobes */
`timescale 1ns/1ps

module statusFlags import cpuPkg::*; (
    input  logic     phi2,
    input  logic     rstAll,
    input  flagModeT flagMode,
    input  byteT     adjVal,
    input  byteT     dbBus,
    input  logic     heldV,
    input  logic     heldC,
    input  logic     bcdCarry,
    input  logic     setC,
    input  logic     clrC,
    input  logic     setI,
    input  logic     clrI,
    input  logic     clrV,
    input  logic     setD,
    input  logic     clrD,
    output statusT   status
);

    statusT statusQ;
    logic   aluZero;
    logic   dbZero;
    logic   carryOut;

    assign aluZero  = (adjVal == 8'h00);
    assign dbZero   = (dbBus == 8'h00);
    // decimal overflow also counts as carry
    assign carryOut = heldC || bcdCarry;

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            statusQ <= statusReset;
        end else begin
            case (flagMode)
                flagsNzcv: begin
                    statusQ[statusN] <= adjVal[7];
                    statusQ[statusZ] <= aluZero;
                    statusQ[statusC] <= carryOut;
                    statusQ[statusV] <= heldV;
                end
                flagsNz: begin
                    statusQ[statusN] <= dbBus[7];
                    statusQ[statusZ] <= dbZero;
                end
                flagsNzc: begin
                    statusQ[statusN] <= adjVal[7];
                    statusQ[statusZ] <= aluZero;
                    statusQ[statusC] <= carryOut;
                end
                flagsBit: begin
                    statusQ[statusN] <= dbBus[7];
                    statusQ[statusV] <= dbBus[6];
                end
                default: begin
                    // set wins when both strobes are up
                    if (setC) begin
                        statusQ[statusC] <= 1'b1;
                    end else if (clrC) begin
                        statusQ[statusC] <= 1'b0;
                    end
                    if (setI) begin
                        statusQ[statusI] <= 1'b1;
                    end else if (clrI) begin
                        statusQ[statusI] <= 1'b0;
                    end
                    if (clrV) begin
                        statusQ[statusV] <= 1'b0;
                    end
                    if (setD) begin
                        statusQ[statusD] <= 1'b1;
                    end else if (clrD) begin
                        statusQ[statusD] <= 1'b0;
                    end
                end
            endcase
        end
    end

    assign status = statusQ;

    // SEC and CLC come from different micro-steps
    assert property (@(posedge phi2) disable iff (rstAll) !(setC && clrC));

endmodule

// ==== logic/userRegs.sv ====
/* accumulator and the X and Y index registers */
`timescale 1ns/1ps

module userRegs import cpuPkg::*; (
    input  logic phi2,
    input  logic rstAll,
    input  byteT sbBus,
    input  byteT adjVal,
    input  logic loadAc,
    input  logic loadX,
    input  logic loadY,
    output byteT accVal,
    output byteT xVal,
    output byteT yVal
);

    // accumulator is written through the decimal adjuster
    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            accVal <= 8'h00;
        end else if (loadAc) begin
            accVal <= adjVal;
        end
    end

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            xVal <= 8'h00;
        end else if (loadX) begin
            xVal <= sbBus;
        end
    end

    always_ff @(posedge phi2 or posedge rstAll) begin
        if (rstAll) begin
            yVal <= 8'h00;
        end else if (loadY) begin
            yVal <= sbBus;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the execution datapath testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tbExecDatapath -o simExec \
    && ./obj_dir/simExec > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// ==== verification/aluPatterns.txt ====
# test aluOp(0 sum 1 and 2 eor 3 or 4 shr) bMode(0 zero 1 db 2 inverted db) carryIn decimal(0 none 1 add 2 sub)
# then accumulator seed, operand, expected accVal and expected status, all hex
1 0 1 0 0 10 20 30 20
1 0 1 1 0 10 20 31 20
1 0 1 0 0 50 50 a0 e0
1 0 1 0 0 ff 01 00 23
1 0 1 0 0 80 80 00 63
1 0 1 1 0 7f 00 80 e0
1 0 1 0 0 d0 90 60 61
2 0 2 1 0 50 20 30 21
2 0 2 1 0 20 50 d0 a0
2 0 2 1 0 50 50 00 23
2 0 2 1 0 80 01 7f 61
2 0 2 1 0 00 01 ff a0
2 0 2 0 0 50 20 2f 21
3 0 1 0 0 80 80 00 63
3 1 1 0 0 f0 3c 30 61
3 1 1 0 0 0f f0 00 63
3 2 1 0 0 ff 0f f0 e1
3 2 1 0 0 5a 5a 00 63
3 3 1 0 0 80 01 81 e1
3 3 1 0 0 00 00 00 63
3 4 1 0 0 00 03 01 61
3 4 1 1 0 00 02 81 e0
3 4 1 0 0 00 01 00 63
4 0 1 0 1 15 27 42 20
4 0 1 1 1 58 46 05 61
4 0 1 0 1 99 01 00 23
4 0 1 0 1 09 09 18 20
4 0 1 0 1 90 90 80 e1
4 0 2 1 2 42 15 27 21
4 0 2 1 2 15 27 88 a0
4 0 2 1 2 50 50 00 23
4 0 2 1 2 00 01 99 a0

// ==== verification/tbExecDatapath.sv ====
/* testbench for the execution datapath: pattern-driven ALU steps, random
   operands, index registers, flag strobes and the program counter */
`timescale 1ns/1ps

module tbExecDatapath import cpuPkg::*; ();

    localparam int clkPeriod   = 100;
    localparam int randomCount = 32;

    logic     phi2;
    logic     rstAll;
    byteT     dataIn;
    sbSrcT    sbSrc;
    dbSrcT    dbSrc;
    aSelT     aSel;
    bSelT     bSel;
    aluOpT    aluOp;
    flagModeT flagMode;
    logic     carryIn;
    logic     decimalAdd;
    logic     decimalSub;
    logic     loadAc;
    logic     loadX;
    logic     loadY;
    logic     setC, clrC, setI, clrI, clrV, setD, clrD;
    logic     pcLoad;
    logic     pcInc;
    byteT     accVal;
    byteT     xVal;
    byteT     yVal;
    statusT   status;
    addrT     pcVal;

    // pattern columns, one entry per file line
    int       patTest[$];
    int       patOp[$];
    int       patBMode[$];
    int       patCarry[$];
    int       patDec[$];
    byteT     patSeed[$];
    byteT     patOperand[$];
    byteT     patAcc[$];
    statusT   patStatus[$];

    logic [31:0] lfsrState = 32'h60f1;
    statusT      modelStatus;
    logic        patternsLoaded = 1'b0;
    logic        openFailed = 1'b0;
    int          errCount = 0;
    int          testCount = 0;
    int          testErrStart;
    string       testName;

    execDatapath i_dut (.*);

    always #(clkPeriod / 2) phi2 = ~phi2;

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic [31:0] nextState;
        nextState = state >> 1;
        if (state[0]) begin
            nextState = nextState ^ 32'h80200003;
        end
        return nextState;
    endfunction

    // one LFSR step per bit taken
    function automatic int randomBits(input int count);
        int value;
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    // returns {overflow, carry, result} for a binary ALU operation
    function automatic logic [9:0] expectAlu(input int op, input byteT a, input byteT b,
                                             input logic ci);
        int   total;
        int   signedTotal;
        byteT res;
        logic c;
        logic v;
        res = 8'h00;
        c = 1'b0;
        v = 1'b0;
        case (op)
            0: begin
                total = int'(a) + int'(b) + int'(ci);
                res = total[7:0];
                c = (total > 255);
                signedTotal = int'($signed(a)) + int'($signed(b)) + int'(ci);
                v = (signedTotal > 127) || (signedTotal < -128);
            end
            1: res = a & b;
            2: res = a ^ b;
            3: res = a | b;
            default: begin
                res = (b >> 1) | (ci ? 8'h80 : 8'h00);
                c = b[0];
            end
        endcase
        return {v, c, res};
    endfunction

    // sum writes NZCV, shift writes NZC, logic ops write only NZ
    function automatic statusT nextStatus(input statusT prev, input int op,
                                          input logic [9:0] outcome);
        statusT s;
        s = prev;
        s[statusN] = outcome[7];
        s[statusZ] = (outcome[7:0] == 8'h00);
        if (op == 0 || op == 4) begin
            s[statusC] = outcome[8];
        end
        if (op == 0) begin
            s[statusV] = outcome[9];
        end
        return s;
    endfunction

    task automatic idleInputs();
        sbSrc      = sbAcc;
        dbSrc      = dbData;
        aSel       = aZero;
        bSel       = bZero;
        aluOp      = aluSum;
        flagMode   = flagsNone;
        carryIn    = 1'b0;
        decimalAdd = 1'b0;
        decimalSub = 1'b0;
        loadAc     = 1'b0;
        loadX      = 1'b0;
        loadY      = 1'b0;
        {setC, clrC, setI, clrI, clrV, setD, clrD} = 7'b0;
        pcLoad     = 1'b0;
        pcInc      = 1'b0;
    endtask

    task automatic reportError(input string msg);
        errCount++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrStart = errCount;
        testCount++;
    endtask

    task automatic endTest();
        if (errCount == testErrStart) begin
            $display("test %s: ok", testName);
        end else begin
            $display("test %s: %0d errors", testName, errCount - testErrStart);
        end
    endtask

    task automatic loadPatterns();
        int     fd;
        int     fields;
        int     t, op, bm, ci, dk;
        byteT   sd, od, ea;
        statusT es;
        string  lineText;
        fd = $fopen("verification/aluPatterns.txt", "r");
        if (fd == 0) begin
            openFailed = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                lineText = "";
                void'($fgets(lineText, fd));
                if (lineText.len() > 1 && lineText.getc(0) != "#") begin
                    fields = $sscanf(lineText, "%d %d %d %d %d %h %h %h %h",
                                     t, op, bm, ci, dk, sd, od, ea, es);
                    if (fields == 9) begin
                        patTest.push_back(t);
                        patOp.push_back(op);
                        patBMode.push_back(bm);
                        patCarry.push_back(ci);
                        patDec.push_back(dk);
                        patSeed.push_back(sd);
                        patOperand.push_back(od);
                        patAcc.push_back(ea);
                        patStatus.push_back(es);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // seed into A, operate against the operand, result back into A
    task automatic runAluStep(input int op, input int bMode, input logic ci,
                              input int decKind, input byteT seed, input byteT operand);
        idleInputs();
        dataIn = seed;
        @(negedge phi2);
        dataIn = operand;
        sbSrc  = sbData;
        loadAc = 1'b1;
        @(negedge phi2);
        loadAc     = 1'b0;
        sbSrc      = sbAcc;
        aSel       = aSb;
        bSel       = bSelT'(bMode[1:0]);
        aluOp      = aluOpT'(op[2:0]);
        carryIn    = ci;
        decimalAdd = (decKind == 1);
        decimalSub = (decKind == 2);
        @(negedge phi2);
        idleInputs();
        sbSrc  = sbHold;
        loadAc = 1'b1;
        if (op == 0) begin
            flagMode = flagsNzcv;
        end else if (op == 4) begin
            flagMode = flagsNzc;
        end
        @(negedge phi2);
        idleInputs();
        // logic results reach N and Z through the accumulator on DB
        if (op >= 1 && op <= 3) begin
            dbSrc    = dbAcc;
            flagMode = flagsNz;
        end
        @(negedge phi2);
        idleInputs();
    endtask

    task automatic checkAluResult(input byteT expAcc, input statusT expStatus);
        if (accVal !== expAcc) begin
            reportError($sformatf("accumulator is %h, expected %h", accVal, expAcc));
        end
        if (status !== expStatus) begin
            reportError($sformatf("status is %h, expected %h", status, expStatus));
        end
        modelStatus = expStatus;
    endtask

    task automatic checkStatus();
        if (status !== modelStatus) begin
            reportError($sformatf("status is %h, expected %h", status, modelStatus));
        end
    endtask

    task automatic loadIndex(input logic toY, input byteT value);
        dataIn = value;
        @(negedge phi2);
        sbSrc    = sbData;
        flagMode = flagsNz;
        loadX    = !toY;
        loadY    = toY;
        @(negedge phi2);
        idleInputs();
        modelStatus[statusN] = value[7];
        modelStatus[statusZ] = (value == 8'h00);
    endtask

    task automatic transferToAcc(input sbSrcT src);
        sbSrc  = src;
        loadAc = 1'b1;
        @(negedge phi2);
        idleInputs();
    endtask

    task automatic bitTest(input byteT value);
        dataIn = value;
        @(negedge phi2);
        flagMode = flagsBit;
        @(negedge phi2);
        idleInputs();
        modelStatus[statusN] = value[7];
        modelStatus[statusV] = value[6];
    endtask

    // high byte goes in first so that it ends up one latch behind
    task automatic loadPc(input addrT value);
        dataIn = value[15:8];
        @(negedge phi2);
        dataIn = value[7:0];
        @(negedge phi2);
        pcLoad = 1'b1;
        @(negedge phi2);
        pcLoad = 1'b0;
    endtask

    task automatic checkPc(input addrT expPc);
        if (pcVal !== expPc) begin
            reportError($sformatf("pcVal is %h, expected %h", pcVal, expPc));
        end
    endtask

    task automatic runAllTests();
        int         i;
        int         k;
        int         op;
        int         curTest;
        byteT       a;
        byteT       b;
        logic       ci;
        logic [9:0] outcome;
        addrT       expPc;

        repeat (8) @(posedge phi2);
        @(negedge phi2);
        rstAll = 1'b0;

        startTest("reset state");
        if (accVal !== 8'h00 || xVal !== 8'h00 || yVal !== 8'h00) begin
            reportError("a user register is not cleared by reset");
        end
        if (status !== 8'h20) begin
            reportError($sformatf("status after reset is %h, expected 20", status));
        end
        checkPc(16'h0000);
        modelStatus = 8'h20;
        endTest();

        if (patTest.size() == 0) begin
            reportError("the pattern file holds no test lines");
        end
        curTest = 0;
        for (i = 0; i < patTest.size(); i++) begin
            if (patTest[i] != curTest) begin
                if (curTest != 0) begin
                    endTest();
                end
                curTest = patTest[i];
                startTest($sformatf("pattern group %0d", curTest));
            end
            runAluStep(patOp[i], patBMode[i], patCarry[i] != 0, patDec[i],
                       patSeed[i], patOperand[i]);
            checkAluResult(patAcc[i], patStatus[i]);
        end
        if (curTest != 0) begin
            endTest();
        end

        startTest("random add");
        for (i = 0; i < randomCount / 2; i++) begin
            a = byteT'(randomBits(8));
            b = byteT'(randomBits(8));
            ci = (randomBits(1) != 0);
            outcome = expectAlu(0, a, b, ci);
            runAluStep(0, 1, ci, 0, a, b);
            checkAluResult(outcome[7:0], nextStatus(modelStatus, 0, outcome));
        end
        endTest();

        startTest("random logic and shift");
        for (i = 0; i < randomCount / 2; i++) begin
            op = 1 + randomBits(2);
            a = byteT'(randomBits(8));
            b = byteT'(randomBits(8));
            ci = (randomBits(1) != 0);
            outcome = expectAlu(op, a, b, ci);
            runAluStep(op, 1, ci, 0, a, b);
            checkAluResult(outcome[7:0], nextStatus(modelStatus, op, outcome));
        end
        endTest();

        startTest("index registers and flags");
        loadIndex(1'b0, 8'h5a);
        if (xVal !== 8'h5a) begin
            reportError($sformatf("xVal is %h, expected 5a", xVal));
        end
        checkStatus();
        loadIndex(1'b1, 8'h80);
        if (yVal !== 8'h80) begin
            reportError($sformatf("yVal is %h, expected 80", yVal));
        end
        checkStatus();
        transferToAcc(sbX);
        if (accVal !== 8'h5a) begin
            reportError($sformatf("accumulator after X transfer is %h, expected 5a", accVal));
        end
        transferToAcc(sbY);
        if (accVal !== 8'h80) begin
            reportError($sformatf("accumulator after Y transfer is %h, expected 80", accVal));
        end
        loadIndex(1'b0, 8'h00);
        checkStatus();
        bitTest(8'h3f);
        checkStatus();
        bitTest(8'hc0);
        checkStatus();
        // each strobe alone, one bit expected to move
        for (k = 0; k < 7; k++) begin
            case (k)
                0: setC = 1'b1;
                1: setI = 1'b1;
                2: setD = 1'b1;
                3: clrC = 1'b1;
                4: clrI = 1'b1;
                5: clrV = 1'b1;
                default: clrD = 1'b1;
            endcase
            @(negedge phi2);
            idleInputs();
            case (k)
                0: modelStatus[statusC] = 1'b1;
                1: modelStatus[statusI] = 1'b1;
                2: modelStatus[statusD] = 1'b1;
                3: modelStatus[statusC] = 1'b0;
                4: modelStatus[statusI] = 1'b0;
                5: modelStatus[statusV] = 1'b0;
                default: modelStatus[statusD] = 1'b0;
            endcase
            checkStatus();
        end
        endTest();

        startTest("program counter");
        expPc = 16'h00fe;
        loadPc(expPc);
        checkPc(expPc);
        repeat (3) begin
            pcInc = 1'b1;
            @(negedge phi2);
            pcInc = 1'b0;
            expPc = expPc + 16'h0001;
            checkPc(expPc);
        end
        expPc = 16'hffff;
        loadPc(expPc);
        checkPc(expPc);
        pcInc = 1'b1;
        @(negedge phi2);
        pcInc = 1'b0;
        expPc = expPc + 16'h0001;
        checkPc(expPc);
        endTest();
    endtask

    initial begin
        phi2   = 1'b0;
        rstAll = 1'b1;
        dataIn = 8'h00;
        idleInputs();
        loadPatterns();
        if (openFailed) begin
            $display("could not open the pattern file verification/aluPatterns.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            patternsLoaded = 1'b1;
            runAllTests();
            $display("totals: %0d tests, %0d errors", testCount, errCount);
            if (errCount == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

    // six cycles per ALU step, plus room for reset and the directed tests
    initial begin
        wait (patternsLoaded);
        #((patTest.size() + randomCount) * 6 * clkPeriod + 100 * clkPeriod);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
